// File: source/fpu_pkg.sv
// single precision only; operands are taken as normal numbers, results are truncated
package fpu_pkg;

  // --------------------
  // word layout
  // --------------------
  localparam int word_w   = 32;
  localparam int exp_w    = 8;
  // mantissa including the hidden bit
  localparam int man_w    = 24;
  localparam int exp_bias = 127;

  // --------------------
  // register map
  // --------------------
  // operand a, bytes 0 to 3
  localparam logic [3:0] reg_a0    = 4'd0;
  // operand b, bytes 4 to 7
  localparam logic [3:0] reg_b0    = 4'd4;
  localparam logic [3:0] reg_op    = 4'd8;
  // start on write, result byte 0 on read
  localparam logic [3:0] reg_start = 4'd9;
  localparam logic [3:0] reg_r0    = 4'd9;

  typedef enum logic {
    op_mul = 1'b0,
    op_div = 1'b1
  } fpu_op_e;

  // ieee fields
  typedef struct packed {
    logic             sign;
    logic [exp_w-1:0] exponent;
    logic [man_w-2:0] fraction;
  } fp_fields_t;

  // fields for the arithmetic units, byte lanes for the bus
  typedef union packed {
    fp_fields_t               f;
    logic [word_w/8-1:0][7:0] b;
  } fp_word_u;

endpackage

// File: source/fpu_regs.sv
// bus is active low on cs/rd/wr; writes are dropped while busy; data_out is zero when idle
module fpu_regs (
  input  logic              clk,
  input  logic              arst,
  input  logic [7:0]        data_in,
  output logic [7:0]        data_out,
  input  logic [3:0]        addr,
  input  logic              cs,
  input  logic              rd,
  input  logic              wr,
  input  logic              busy,
  input  logic              result_load,
  input  fpu_pkg::fp_word_u result,
  output fpu_pkg::fp_word_u operand_a,
  output fpu_pkg::fp_word_u operand_b,
  output fpu_pkg::fpu_op_e  op,
  output logic              start_req
);
  import fpu_pkg::*;

  logic     wr_en;
  logic     rd_en;
  fp_word_u result_q;

  assign wr_en = !cs && !wr;
  assign rd_en = !cs && !rd;

  assign start_req = wr_en && (addr == reg_start) && !busy;

  // --------------------
  // register writes
  // --------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      operand_a <= '0;
      operand_b <= '0;
      op        <= op_mul;
    end else if (result_load) begin
      // result also lands in operand a so commands can be chained
      operand_a <= result;
    end else if (wr_en && !busy) begin
      case (addr) inside
        [reg_a0 : reg_a0 + 4'd3]: operand_a.b[2'(addr - reg_a0)] <= data_in;
        [reg_b0 : reg_b0 + 4'd3]: operand_b.b[2'(addr - reg_b0)] <= data_in;
        reg_op:                   op <= fpu_op_e'(data_in[0]);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (result_load) begin
      result_q <= result;
    end
  end

  // --------------------
  // read mux
  // --------------------
  always_comb begin
    data_out = '0;
    if (rd_en) begin
      case (addr) inside
        [reg_a0 : reg_a0 + 4'd3]: data_out = operand_a.b[2'(addr - reg_a0)];
        [reg_b0 : reg_b0 + 4'd3]: data_out = operand_b.b[2'(addr - reg_b0)];
        reg_op:                   data_out = {7'b0, op};
        [reg_r0 : reg_r0 + 4'd3]: data_out = result_q.b[2'(addr - reg_r0)];
        default:                  data_out = '0;
      endcase
    end
  end

endmodule

// File: source/fpu_sequencer.sv
// one command at a time; op must not change while busy, which the register block ensures
module fpu_sequencer (
  input  logic             clk,
  input  logic             arst,
  input  logic             start_req,
  input  fpu_pkg::fpu_op_e op,
  input  logic             end_ack,
  unit_if.ctrl             mul,
  unit_if.ctrl             div,
  output logic             result_load,
  output logic             busy,
  output logic             cmd_end
);
  import fpu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_finish,
    st_wait_ack
  } seq_state_e;

  seq_state_e state;
  logic       unit_done;

  assign unit_done = (op == op_div) ? div.done : mul.done;

  // --------------------
  // command fsm
  // --------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state     <= st_idle;
      mul.start <= 1'b0;
      div.start <= 1'b0;
    end else begin
      // start follows busy by a cycle and drops as soon as done is seen
      mul.start <= (state == st_run) && (op == op_mul) && !unit_done;
      div.start <= (state == st_run) && (op == op_div) && !unit_done;
      case (state)
        st_idle: begin
          if (start_req) begin
            state <= st_run;
          end
        end
        st_run: begin
          if (unit_done) begin
            state <= st_finish;
          end
        end
        // result captured on the way out of here
        st_finish: state <= st_wait_ack;
        st_wait_ack: begin
          if (end_ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy        = (state != st_idle);
  assign result_load = (state == st_finish);
  assign cmd_end     = (state == st_wait_ack);

  // a raised start belongs to the unit op still selects, so at most one is high
  a_one_start: assert property (@(posedge clk) disable iff (arst)
    (!mul.start || op == op_mul) && (!div.start || op == op_div));

endmodule

// File: source/fpu_top.sv
// normal operands only, exponents must keep the result in range, results truncated
module fpu_top #(
  parameter int mul_steps = fpu_pkg::man_w,
  parameter int div_steps = fpu_pkg::man_w + 1
) (
  input  logic       clk,
  input  logic       arst,
  input  logic [7:0] data_in,
  output logic [7:0] data_out,
  input  logic [3:0] addr,
  input  logic       cs,
  input  logic       rd,
  input  logic       wr,
  input  logic       end_ack,
  output logic       cmd_end,
  output logic       busy
);
  import fpu_pkg::*;

  fp_word_u operand_a;
  fp_word_u operand_b;
  fp_word_u result;
  fpu_op_e  op;
  logic     start_req;
  logic     result_load;

  unit_if #(.width(word_w)) mul_bus ();
  unit_if #(.width(word_w)) div_bus ();

  // both units see the same operands, only the selected one is started
  assign mul_bus.operand_a = operand_a;
  assign mul_bus.operand_b = operand_b;
  assign div_bus.operand_a = operand_a;
  assign div_bus.operand_b = operand_b;

  assign result = (op == op_div) ? div_bus.result : mul_bus.result;

  fpu_regs regs_i (
    .clk, .arst, .data_in, .data_out, .addr, .cs, .rd, .wr,
    .busy, .result_load, .result, .operand_a, .operand_b, .op, .start_req
  );

  fpu_sequencer sequencer_i (
    .clk, .arst, .start_req, .op, .end_ack,
    .mul(mul_bus.ctrl), .div(div_bus.ctrl),
    .result_load, .busy, .cmd_end
  );

  mantissa_multiplier #(.mul_steps(mul_steps)) multiplier_i (
    .clk, .arst, .unit(mul_bus.unit)
  );

  mantissa_divider #(.div_steps(div_steps)) divider_i (
    .clk, .arst, .unit(div_bus.unit)
  );

endmodule

// File: source/mantissa_divider.sv
// correct only for div_steps equal to man_w+1; divisor must be normal, quotient is truncated
module mantissa_divider #(
  parameter int div_steps = fpu_pkg::man_w + 1
) (
  input logic  clk,
  input logic  arst,
  unit_if.unit unit
);
  import fpu_pkg::*;

  localparam int cnt_w = $clog2(div_steps + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_trial,
    st_shift,
    st_norm,
    st_done
  } div_state_e;

  div_state_e       state;
  logic [cnt_w-1:0] cnt;
  // remainder stays below twice the divisor, one bit over the mantissa
  logic [man_w:0]   rem;
  logic [man_w-1:0] divisor;
  logic [man_w:0]   quotient;
  logic [man_w+1:0] diff;
  logic [exp_w+1:0] exp_diff;
  logic             sign;

  // trial subtraction, negative means the bit is zero and nothing is restored
  assign diff      = {1'b0, rem} - {2'b00, divisor};
  assign unit.done = (state == st_done);

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (unit.start) begin
            state <= st_load;
          end
        end
        st_load: begin
          cnt   <= '0;
          state <= st_trial;
        end
        st_trial: begin
          cnt   <= cnt + 1'b1;
          state <= st_shift;
        end
        st_shift: state <= (cnt == cnt_w'(div_steps)) ? st_norm : st_trial;
        st_norm:  state <= st_done;
        st_done: begin
          if (!unit.start) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------
  always_ff @(posedge clk) begin
    case (state)
      st_load: begin
        rem      <= {2'b01, unit.operand_a.f.fraction};
        divisor  <= {1'b1, unit.operand_b.f.fraction};
        quotient <= '0;
        exp_diff <= {2'b00, unit.operand_a.f.exponent} - {2'b00, unit.operand_b.f.exponent}
                    + (exp_w + 2)'(exp_bias);
        sign     <= unit.operand_a.f.sign ^ unit.operand_b.f.sign;
      end
      st_trial: begin
        if (!diff[man_w+1]) begin
          rem <= diff[man_w:0];
        end
        quotient <= {quotient[man_w-1:0], !diff[man_w+1]};
      end
      st_shift: rem <= {rem[man_w-1:0], 1'b0};
      st_norm: begin
        unit.result.f.sign <= sign;
        // quotient in (0.5,2); without the top bit it needs one more shift
        if (quotient[man_w]) begin
          unit.result.f.fraction <= quotient[man_w-1:1];
          unit.result.f.exponent <= exp_diff[exp_w-1:0];
        end else begin
          unit.result.f.fraction <= quotient[man_w-2:0];
          unit.result.f.exponent <= exp_w'(exp_diff - 1'b1);
        end
      end
      default: ;
    endcase
  end

  // a zero exponent would clear the hidden bit the loop relies on
  a_divisor_normal: assert property (@(posedge clk) disable iff (arst)
    (state == st_idle && unit.start) |-> (unit.operand_b.f.exponent != '0));

endmodule

// File: source/mantissa_multiplier.sv
// correct only for mul_steps equal to man_w; normal operands, truncated result, no overflow check
module mantissa_multiplier #(
  parameter int mul_steps = fpu_pkg::man_w
) (
  input logic  clk,
  input logic  arst,
  unit_if.unit unit
);
  import fpu_pkg::*;

  localparam int cnt_w  = $clog2(mul_steps + 1);
  // extra top bit keeps the carry of each add
  localparam int prod_w = 2 * man_w + 1;

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_add,
    st_shift,
    st_norm,
    st_done
  } mul_state_e;

  mul_state_e         state;
  logic [cnt_w-1:0]   cnt;
  logic [man_w-1:0]   multiplicand;
  logic [prod_w-1:0]  prod;
  logic [2*man_w-1:0] product;
  logic [exp_w+1:0]   exp_sum;
  logic               sign;

  assign product   = prod[2*man_w-1:0];
  assign unit.done = (state == st_done);

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (unit.start) begin
            state <= st_load;
          end
        end
        st_load: begin
          cnt   <= '0;
          state <= st_add;
        end
        st_add: begin
          cnt   <= cnt + 1'b1;
          state <= st_shift;
        end
        st_shift: state <= (cnt == cnt_w'(mul_steps)) ? st_norm : st_add;
        st_norm:  state <= st_done;
        st_done: begin
          if (!unit.start) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------
  always_ff @(posedge clk) begin
    case (state)
      st_load: begin
        multiplicand <= {1'b1, unit.operand_a.f.fraction};
        // multiplier sits in the low half and drains out to the right
        prod    <= {{(man_w + 1){1'b0}}, 1'b1, unit.operand_b.f.fraction};
        exp_sum <= {2'b00, unit.operand_a.f.exponent} + {2'b00, unit.operand_b.f.exponent}
                   - (exp_w + 2)'(exp_bias);
        sign    <= unit.operand_a.f.sign ^ unit.operand_b.f.sign;
      end
      st_add: begin
        if (prod[0]) begin
          prod[prod_w-1:man_w] <= prod[prod_w-1:man_w] + {1'b0, multiplicand};
        end
      end
      st_shift: prod <= prod >> 1;
      st_norm: begin
        unit.result.f.sign <= sign;
        // product in [1,4), a leading one in the top bit means 1x.xxx
        if (product[2*man_w-1]) begin
          unit.result.f.fraction <= product[2*man_w-2:man_w];
          unit.result.f.exponent <= exp_w'(exp_sum + 1'b1);
        end else begin
          unit.result.f.fraction <= product[2*man_w-3:man_w-1];
          unit.result.f.exponent <= exp_sum[exp_w-1:0];
        end
      end
      default: ;
    endcase
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (arst) cnt <= cnt_w'(mul_steps));

endmodule

// File: source/unit_if.sv
// operands must stay stable while start is high; width must equal the package word width
interface unit_if #(
  parameter int width = fpu_pkg::word_w
) ();
  import fpu_pkg::*;

  logic     start;
  fp_word_u operand_a;
  fp_word_u operand_b;
  logic     done;
  fp_word_u result;

  // the union fixes the layout, so a different width cannot be honoured
  if (width != $bits(fp_word_u)) begin : g_width_check
    $error("unit_if width differs from the floating-point word");
  end

  modport ctrl (
    output start,
    input  done
  );

  modport unit (
    input  start,
    input  operand_a,
    input  operand_b,
    output done,
    output result
  );

endinterface

// File: tb.f
+incdir+verif
source/fpu_pkg.sv
source/unit_if.sv
source/fpu_regs.sv
source/fpu_sequencer.sv
source/mantissa_multiplier.sv
source/mantissa_divider.sv
source/fpu_top.sv
verif/fpu_tb.sv

// File: verif/fpu_model.svh
// expects fpu_pkg imported by the including module; operands normal, results truncated
`ifndef fpu_model_svh
`define fpu_model_svh

// --------------------
// multiply
// --------------------
function automatic logic [31:0] model_mul(input logic [31:0] a, input logic [31:0] b);
  logic [23:0] ma;
  logic [23:0] mb;
  logic [47:0] p;
  logic [22:0] frac;
  int          e;
  ma = {1'b1, a[22:0]};
  mb = {1'b1, b[22:0]};
  p  = ma * mb;
  // product of two mantissas lies in [1,4)
  if (p[47]) begin
    frac = p[46:24];
    e    = int'(a[30:23]) + int'(b[30:23]) - (exp_bias - 1);
  end else begin
    frac = p[45:23];
    e    = int'(a[30:23]) + int'(b[30:23]) - exp_bias;
  end
  return {a[31] ^ b[31], 8'(e), frac};
endfunction

// --------------------
// divide
// --------------------
function automatic logic [31:0] model_div(input logic [31:0] a, input logic [31:0] b);
  logic [23:0] ma;
  logic [23:0] mb;
  logic [47:0] q;
  logic [22:0] frac;
  int          e;
  ma = {1'b1, a[22:0]};
  mb = {1'b1, b[22:0]};
  q  = {ma, 24'b0} / {24'b0, mb};
  // quotient in (0.5,2), bit 24 is the integer one
  if (q[24]) begin
    frac = q[23:1];
    e    = int'(a[30:23]) - int'(b[30:23]) + exp_bias;
  end else begin
    frac = q[22:0];
    e    = int'(a[30:23]) - int'(b[30:23]) + exp_bias - 1;
  end
  return {a[31] ^ b[31], 8'(e), frac};
endfunction

`endif

// File: verif/fpu_tb.sv
// random normal operands from seed 26; chained ops pick b so the exponent stays in range
module fpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fpu_pkg::*;

  `include "fpu_model.svh"

  localparam int      mul_steps  = man_w;
  localparam int      div_steps  = man_w + 1;
  localparam int      n_each     = 100;
  // reset check, readback, then a main and a chained op per pair
  localparam int      n_tests    = 2 + 4 * n_each;
  localparam realtime clk_period = 40.0;
  localparam realtime wd_time    = n_tests * (2 * div_steps + 40) * clk_period;

  logic       clk = 1'b0;
  logic       arst;
  logic [7:0] data_in;
  logic [7:0] data_out;
  logic [3:0] addr;
  logic       cs;
  logic       rd;
  logic       wr;
  logic       end_ack;
  logic       cmd_end;
  logic       busy;
  integer     seed;
  int         errors;
  int         checks;

  fpu_top #(.mul_steps(mul_steps), .div_steps(div_steps)) fpu_top_i (
    .clk, .arst, .data_in, .data_out, .addr, .cs, .rd, .wr, .end_ack, .cmd_end, .busy
  );

  always #(clk_period / 2) clk = ~clk;

  // --------------------
  // bus access
  // --------------------
  task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
    @(posedge clk);
    addr    <= a;
    data_in <= d;
    cs      <= 1'b0;
    wr      <= 1'b0;
    rd      <= 1'b1;
  endtask

  task automatic bus_read(input logic [3:0] a, output logic [7:0] d);
    @(posedge clk);
    addr <= a;
    cs   <= 1'b0;
    rd   <= 1'b0;
    wr   <= 1'b1;
    @(negedge clk);
    d = data_out;
  endtask

  task automatic bus_idle;
    @(posedge clk);
    cs <= 1'b1;
    rd <= 1'b1;
    wr <= 1'b1;
  endtask

  task automatic write_word(input logic [3:0] base, input logic [31:0] value);
    for (int i = 0; i < 4; i++) begin
      bus_write(4'(base + i), value[8*i +: 8]);
    end
  endtask

  task automatic read_word(input logic [3:0] base, output logic [31:0] value);
    logic [7:0] byte_v;
    for (int i = 0; i < 4; i++) begin
      bus_read(4'(base + i), byte_v);
      value[8*i +: 8] = byte_v;
    end
    bus_idle;
  endtask

  // --------------------
  // checks
  // --------------------
  task automatic expect_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // call at a falling edge
  task automatic expect_flags(input string when, input logic exp_busy, input logic exp_end);
    checks++;
    if (busy !== exp_busy || cmd_end !== exp_end) begin
      errors++;
      $display("FAIL %0t: %s busy=%b cmd_end=%b, expected %b %b",
               $time, when, busy, cmd_end, exp_busy, exp_end);
    end
  endtask

  task automatic start_command;
    bus_write(reg_start, 8'h00);
    bus_idle;
    @(negedge clk);
    expect_flags("after start write", 1'b1, 1'b0);
  endtask

  task automatic wait_cmd_end;
    int n;
    n = 0;
    while (!cmd_end && n < 2 * div_steps + 20) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_end) begin
      errors++;
      $display("cmd_end never rose within %0d cycles of the start write", n);
    end
  endtask

  task automatic release_ack;
    @(posedge clk);
    end_ack <= 1'b1;
    @(negedge clk);
    expect_flags("before end_ack is sampled", 1'b1, 1'b1);
    @(posedge clk);
    end_ack <= 1'b0;
    @(negedge clk);
    expect_flags("after end_ack", 1'b0, 1'b0);
  endtask

  // end_ack held low while the result is read twice and a start write is tried
  task automatic hold_back_pressure(input logic [31:0] exp);
    logic [31:0] got;
    int          k;
    read_word(reg_r0, got);
    expect_word("held result", got, exp);
    start_command_ignored: begin
      bus_write(reg_start, 8'h00);
      bus_idle;
      @(negedge clk);
      expect_flags("start write while waiting for end_ack", 1'b1, 1'b1);
    end
    k = 1 + ($unsigned($random(seed)) % 4);
    repeat (k) begin
      @(negedge clk);
      expect_flags("while end_ack is low", 1'b1, 1'b1);
    end
    read_word(reg_r0, got);
    expect_word("result after hold", got, exp);
    release_ack;
    repeat (2) begin
      @(negedge clk);
      expect_flags("after release, no second command", 1'b0, 1'b0);
    end
  endtask

  // --------------------
  // stimulus
  // --------------------
  function automatic logic [31:0] random_operand;
    logic [7:0] e;
    e = 8'(64 + ($unsigned($random(seed)) % 127));
    return {1'($random(seed)), e, 23'($random(seed))};
  endfunction

  // b exponent chosen so the chained result lands near the bias
  function automatic logic [31:0] chain_operand(input fpu_op_e op, input logic [31:0] a);
    int eb;
    eb = (op == op_div) ? int'(a[30:23]) : 254 - int'(a[30:23]);
    if (eb < 1) eb = 1;
    if (eb > 254) eb = 254;
    return {1'($random(seed)), 8'(eb), 23'($random(seed))};
  endfunction

  function automatic logic [31:0] model_result(input fpu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
    return (op == op_div) ? model_div(a, b) : model_mul(a, b);
  endfunction

  task automatic run_pair(input fpu_op_e op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp1;
    logic [31:0] exp2;
    logic [31:0] got;
    fpu_op_e     op2;
    a = random_operand();
    b = random_operand();
    write_word(reg_a0, a);
    write_word(reg_b0, b);
    bus_write(reg_op, {7'b0, op});
    start_command;
    wait_cmd_end;
    exp1 = model_result(op, a, b);
    read_word(reg_r0, got);
    expect_word(op == op_div ? "quotient" : "product", got, exp1);
    read_word(reg_a0, got);
    expect_word("operand a after result", got, exp1);
    release_ack;
    // chained op keeps the result in operand a
    op2 = fpu_op_e'(1'($random(seed)));
    b   = chain_operand(op2, exp1);
    bus_write(reg_op, {7'b0, op2});
    write_word(reg_b0, b);
    start_command;
    wait_cmd_end;
    exp2 = model_result(op2, exp1, b);
    hold_back_pressure(exp2);
    read_word(reg_a0, got);
    expect_word("chained operand a", got, exp2);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] got;
    logic [7:0]  byte_v;
    fpu_op_e     op;
    seed    = 26;
    errors  = 0;
    checks  = 0;
    arst    = 1'b1;
    data_in = '0;
    addr    = '0;
    cs      = 1'b1;
    rd      = 1'b1;
    wr      = 1'b1;
    end_ack = 1'b0;
    repeat (3) @(posedge clk);
    arst <= 1'b0;

    // reset state
    @(negedge clk);
    expect_flags("after reset", 1'b0, 1'b0);
    read_word(reg_a0, got);
    expect_word("operand a after reset", got, '0);
    read_word(reg_b0, got);
    expect_word("operand b after reset", got, '0);
    bus_read(reg_op, byte_v);
    bus_idle;
    expect_word("op after reset", {24'b0, byte_v}, '0);

    // register readback
    a  = $random(seed);
    b  = $random(seed);
    op = fpu_op_e'(1'($random(seed)));
    write_word(reg_a0, a);
    write_word(reg_b0, b);
    bus_write(reg_op, {7'b0, op});
    bus_idle;
    read_word(reg_a0, got);
    expect_word("operand a readback", got, a);
    read_word(reg_b0, got);
    expect_word("operand b readback", got, b);
    bus_read(reg_op, byte_v);
    bus_idle;
    expect_word("op readback", {24'b0, byte_v}, {31'b0, op});

    repeat (n_each) run_pair(op_mul);
    repeat (n_each) run_pair(op_div);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(wd_time);
    $display("timeout: run stopped at %0t before the test sequence finished", $time);
    $display("tests failed");
    $finish;
  end

endmodule
